/* list.f */
bypass_pkg.sv
bypass_ctrl.sv
bypass_l2_port.sv
bypass_sysbus_port.sv
dcache_bypass.sv
tb_dcache_bypass.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_dcache_bypass -f list.f

out=$(./obj_dir/Vtb_dcache_bypass 2>&1) || true
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -qx "all tests passed"

/* tb_dcache_bypass.sv */
// ==================================================
// Directed testbench with TLB, L2 and system-bus
// models. L2 is selected by physical address bit 31.
// ==================================================
`timescale 1ns/1ps

module tb_dcache_bypass
  import bypass_pkg::*;
();

  localparam int TIMEOUT = 100;

  logic       clk;
  logic       rst;
  core_req_t  core_req;
  core_resp_t core_resp;
  logic       tlb_req_valid;
  tlb_req_t   tlb_req;
  logic       tlb_req_ready;
  logic       tlb_resp_valid;
  tlb_resp_t  tlb_resp;
  logic       tlb_resp_ready;
  logic       l2_req_valid;
  l2_req_t    l2_req;
  logic       l2_req_ready;
  logic       l2_resp_valid;
  l2_resp_t   l2_resp;
  logic       l2_resp_ready;
  logic       ar_valid;
  sys_ar_t    ar;
  logic       ar_ready;
  logic       aw_valid;
  sys_aw_t    aw;
  logic       aw_ready;
  logic       w_valid;
  sys_w_t     w;
  logic       w_ready;
  logic       r_valid;
  sys_r_t     r;
  logic       r_ready;
  logic       b_valid;
  sys_b_t     b;
  logic       b_ready;

  // Model settings written by the tests
  logic              to_l2       = 1'b1;
  logic              fault       = 1'b0;
  excp_cause_e       fault_cause = NONE;
  int                l2_dly      = 0;
  int                ar_dly      = 0;
  int                aw_dly      = 0;
  int                w_dly       = 0;
  logic [LINE_W-1:0] l2_line     = '0;
  logic [DATA_W-1:0] r_word      = '0;
  int                done_count  = 0;
  int                seed        = 32'h42d2_b3a7;

  // Captured by the models at each handshake
  l2_req_t l2_seen;
  sys_ar_t ar_seen;
  sys_aw_t aw_seen;
  sys_w_t  w_seen;
  int      resp_count;
  int      bus_req_count;

  dcache_bypass #(
    .L2_SEL_BIT(31)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==================================================
  // Helpers and compare tasks
  // ==================================================
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic logic [DATA_W-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // TLB model maps ppn to the vpn with bit 19 set for L2
  function automatic logic [PPN_W-1:0] page_of(input logic [VPN_W-1:0] vpn, input logic l2);
    logic [PPN_W-1:0] ppn;
    ppn     = {1'b0, vpn};
    ppn[19] = l2;
    return ppn;
  endfunction

  function automatic logic [PADDR_W-1:0] phys_addr(input logic [VADDR_W-1:0] va,
                                                  input logic l2);
    return {page_of(va[VADDR_W-1:PAGE_OFS_W], l2), va[PAGE_OFS_W-1:0]};
  endfunction

  task automatic resp_check(input core_resp_t got, input core_resp_t exp, input bit with_data);
    core_resp_t got_m;
    core_resp_t exp_m;
    got_m = got;
    exp_m = exp;
    if (!with_data) begin
      got_m.rdata = '0;
      exp_m.rdata = '0;
    end
    if (got_m !== exp_m)
      stop_with_error($sformatf("CHECK FAILED core_resp got %h exp %h", got_m, exp_m));
  endtask

  task automatic tlb_req_check(input tlb_req_t got, input tlb_req_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED tlb_req got %h exp %h", got, exp));
  endtask

  task automatic l2_req_check(input l2_req_t got, input l2_req_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED l2_req got %h exp %h", got, exp));
  endtask

  task automatic ar_check(input sys_ar_t got, input sys_ar_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED ar got %h exp %h", got, exp));
  endtask

  task automatic aw_check(input sys_aw_t got, input sys_aw_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED aw got %h exp %h", got, exp));
  endtask

  task automatic w_check(input sys_w_t got, input sys_w_t exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED w got %h exp %h", got, exp));
  endtask

  task automatic ctrl_low_check(input logic [9:0] got);
    if (got !== 10'h0)
      stop_with_error($sformatf("CHECK FAILED control outputs got %h exp %h", got, 10'h0));
  endtask

  // One-cycle core strobe and the TLB request that follows it
  task automatic issue(input logic we, input logic [VADDR_W-1:0] addr,
                       input logic [DATA_W-1:0] wdata, input logic [7:0] mask);
    tlb_req_t exp_tlb;
    int       n;
    exp_tlb.vpn         = addr[VADDR_W-1:PAGE_OFS_W];
    exp_tlb.access_type = we ? STORE : LOAD;
    @(posedge clk);
    core_req.re    <= !we;
    core_req.we    <= we;
    core_req.addr  <= addr;
    core_req.wdata <= wdata;
    core_req.mask  <= mask;
    @(posedge clk);
    core_req.re <= 1'b0;
    core_req.we <= 1'b0;
    @(negedge clk);
    if (!tlb_req_valid) stop_with_error("no TLB request one cycle after the core request");
    n = 0;
    while (!tlb_req_ready) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_with_error("TLB request was never accepted");
    end
    tlb_req_check(tlb_req, exp_tlb);
  endtask

  task automatic wait_resp(output core_resp_t resp);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) stop_with_error("no core response within the timeout");
    end while (!core_resp.valid);
    resp = core_resp;
  endtask

  // Exactly one response per access
  task automatic count_responses();
    repeat (3) @(negedge clk);
    done_count++;
    if (resp_count != done_count)
      stop_with_error($sformatf("expected %0d core responses, saw %0d", done_count, resp_count));
  endtask

  // ==================================================
  // Models
  // ==================================================
  initial begin : tlb_model
    int               n;
    logic [VPN_W-1:0] vpn;
    tlb_req_ready  <= 1'b0;
    tlb_resp_valid <= 1'b0;
    tlb_resp       <= '0;
    forever begin
      @(posedge clk);
      if (tlb_req_valid && !rst) begin
        tlb_req_ready <= 1'b1;
        @(posedge clk);
        tlb_req_ready <= 1'b0;
        vpn = tlb_req.vpn;
        repeat (2) @(posedge clk);
        tlb_resp_valid      <= 1'b1;
        tlb_resp.ppn        <= page_of(vpn, to_l2);
        tlb_resp.excp_valid <= fault;
        tlb_resp.excp_cause <= fault ? fault_cause : NONE;
        n = 0;
        do begin
          @(posedge clk);
          n++;
          if (n > TIMEOUT) stop_with_error("TLB response was never accepted");
        end while (!tlb_resp_ready);
        tlb_resp_valid <= 1'b0;
      end
    end
  end

  initial begin : l2_model
    int n;
    l2_req_ready  <= 1'b0;
    l2_resp_valid <= 1'b0;
    l2_resp       <= '0;
    forever begin
      @(posedge clk);
      if (l2_req_valid && !rst) begin
        repeat (l2_dly) @(posedge clk);
        l2_req_ready <= 1'b1;
        @(posedge clk);
        l2_req_ready <= 1'b0;
        l2_seen = l2_req;
        if (l2_seen.req_type == REQ_READ) begin
          repeat (2) @(posedge clk);
          l2_resp_valid <= 1'b1;
          l2_resp.data  <= l2_line;
          l2_resp.tid   <= l2_seen.tid;
          n = 0;
          do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) stop_with_error("L2 response was never accepted");
          end while (!l2_resp_ready);
          l2_resp_valid <= 1'b0;
        end
      end
    end
  end

  initial begin : sys_model
    int n;
    int k;
    ar_ready <= 1'b0;
    aw_ready <= 1'b0;
    w_ready  <= 1'b0;
    r_valid  <= 1'b0;
    r        <= '0;
    b_valid  <= 1'b0;
    b        <= '0;
    forever begin
      @(posedge clk);
      if (ar_valid && !rst) begin
        repeat (ar_dly) @(posedge clk);
        ar_ready <= 1'b1;
        @(posedge clk);
        ar_ready <= 1'b0;
        ar_seen = ar;
        repeat (2) @(posedge clk);
        r_valid <= 1'b1;
        r.id    <= ar_seen.id;
        r.data  <= r_word;
        n = 0;
        do begin
          @(posedge clk);
          n++;
          if (n > TIMEOUT) stop_with_error("R beat was never accepted");
        end while (!r_ready);
        r_valid <= 1'b0;
      end else if (aw_valid && w_valid && !rst) begin
        // Separate one-cycle ready pulses for AW and W
        k = 0;
        while (k <= aw_dly || k <= w_dly) begin
          aw_ready <= (k == aw_dly);
          w_ready  <= (k == w_dly);
          @(posedge clk);
          if (aw_valid && aw_ready) aw_seen = aw;
          if (w_valid && w_ready) w_seen = w;
          k++;
        end
        aw_ready <= 1'b0;
        w_ready  <= 1'b0;
        repeat (2) @(posedge clk);
        b_valid <= 1'b1;
        b.id    <= aw_seen.id;
        n = 0;
        do begin
          @(posedge clk);
          n++;
          if (n > TIMEOUT) stop_with_error("B response was never accepted");
        end while (!b_ready);
        b_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      resp_count    <= 0;
      bus_req_count <= 0;
    end else begin
      if (core_resp.valid) resp_count <= resp_count + 1;
      if (l2_req_valid || ar_valid || aw_valid) bus_req_count <= bus_req_count + 1;
    end
  end

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_state();
    @(negedge clk);
    ctrl_low_check({core_resp.valid, tlb_req_valid, tlb_resp_ready, l2_req_valid,
                    l2_resp_ready, ar_valid, aw_valid, w_valid, r_ready, b_ready});
  endtask

  task automatic l2_store(input int lane);
    core_resp_t         resp;
    core_resp_t         exp;
    l2_req_t            exp_req;
    logic [VADDR_W-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [7:0]         mask;
    logic [TID_W-1:0]   tid;
    addr      = {27'h2a5_1c30, 12'ha40};
    addr[4:3] = lane[1:0];
    wdata     = rand64();
    mask      = 8'hff >> lane;
    tid       = TID_W'(done_count);
    to_l2     = 1'b1;
    fault     = 1'b0;
    l2_dly    = 3 + lane;
    issue(1'b1, addr, wdata, mask);
    wait_resp(resp);
    if (!(l2_req_valid && l2_req_ready))
      stop_with_error("L2 store completed outside the L2 request handshake");
    exp       = '0;
    exp.valid = 1'b1;
    resp_check(resp, exp, 1'b0);
    count_responses();
    exp_req                              = '0;
    exp_req.paddr                        = phys_addr(addr, 1'b1);
    exp_req.data[lane*DATA_W +: DATA_W]  = wdata;
    exp_req.mask[lane*8 +: 8]            = mask;
    exp_req.tid                          = tid;
    exp_req.req_type                     = REQ_WRITE;
    l2_req_check(l2_seen, exp_req);
  endtask

  task automatic l2_load_lane();
    core_resp_t         resp;
    core_resp_t         exp;
    l2_req_t            exp_req;
    logic [VADDR_W-1:0] addr;
    logic [TID_W-1:0]   tid;
    addr    = {27'h0f0_3a21, 12'h650};
    tid     = TID_W'(done_count);
    to_l2   = 1'b1;
    fault   = 1'b0;
    l2_dly  = 1;
    l2_line = {rand64(), rand64(), rand64(), rand64()};
    issue(1'b0, addr, '0, '0);
    wait_resp(resp);
    if (!(l2_resp_valid && l2_resp_ready))
      stop_with_error("L2 load completed outside the L2 response handshake");
    exp       = '0;
    exp.valid = 1'b1;
    exp.rdata = l2_line[addr[4:3]*DATA_W +: DATA_W];
    resp_check(resp, exp, 1'b1);
    count_responses();
    exp_req          = '0;
    exp_req.paddr    = phys_addr(addr, 1'b1);
    exp_req.tid      = tid;
    exp_req.req_type = REQ_READ;
    l2_req_check(l2_seen, exp_req);
  endtask

  task automatic sys_store(input int aw_delay, input int w_delay);
    core_resp_t         resp;
    core_resp_t         exp;
    sys_aw_t            exp_aw;
    sys_w_t             exp_w;
    logic [VADDR_W-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [TID_W-1:0]   tid;
    addr   = {27'h155_0c08, 12'h318};
    wdata  = rand64();
    tid    = TID_W'(done_count);
    to_l2  = 1'b0;
    fault  = 1'b0;
    aw_dly = aw_delay;
    w_dly  = w_delay;
    issue(1'b1, addr, wdata, 8'h3c);
    wait_resp(resp);
    if (!(b_valid && b_ready))
      stop_with_error("system-bus store completed before the B handshake");
    exp       = '0;
    exp.valid = 1'b1;
    resp_check(resp, exp, 1'b0);
    count_responses();
    exp_aw.id   = BUS_ID_W'(tid);
    exp_aw.addr = phys_addr(addr, 1'b0);
    aw_check(aw_seen, exp_aw);
    exp_w.data = wdata;
    exp_w.strb = 8'h3c;
    w_check(w_seen, exp_w);
  endtask

  task automatic sys_load();
    core_resp_t         resp;
    core_resp_t         exp;
    sys_ar_t            exp_ar;
    logic [VADDR_W-1:0] addr;
    logic [TID_W-1:0]   tid;
    addr   = {27'h0c3_9e15, 12'h7b8};
    tid    = TID_W'(done_count);
    to_l2  = 1'b0;
    fault  = 1'b0;
    ar_dly = 3;
    r_word = rand64();
    issue(1'b0, addr, '0, '0);
    wait_resp(resp);
    if (!(r_valid && r_ready))
      stop_with_error("system-bus load completed outside the R handshake");
    exp       = '0;
    exp.valid = 1'b1;
    exp.rdata = r_word;
    resp_check(resp, exp, 1'b1);
    count_responses();
    exp_ar.id   = BUS_ID_W'(tid);
    exp_ar.addr = phys_addr(addr, 1'b0);
    ar_check(ar_seen, exp_ar);
  endtask

  // Fault reaches the core with no bus traffic and the tid moves on
  task automatic xlate_fault(input logic we, input excp_cause_e cause);
    core_resp_t resp;
    core_resp_t exp;
    int         reqs_before;
    reqs_before = bus_req_count;
    to_l2       = 1'b1;
    fault       = 1'b1;
    fault_cause = cause;
    issue(we, {27'h3c0_0101, 12'h008}, '0, '0);
    wait_resp(resp);
    if (!(tlb_resp_valid && tlb_resp_ready))
      stop_with_error("fault response came outside the TLB response handshake");
    exp            = '0;
    exp.valid      = 1'b1;
    exp.excp_valid = 1'b1;
    exp.excp_cause = cause;
    resp_check(resp, exp, 1'b0);
    count_responses();
    if (bus_req_count != reqs_before)
      stop_with_error("a bus request was made for a faulting access");
    fault = 1'b0;
    l2_store(1);
  endtask

  initial begin : main
    core_req <= '0;
    rst      <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    reset_state();
    for (int lane = 0; lane < 4; lane++) l2_store(lane);
    l2_load_lane();
    sys_store(2, 5);
    sys_store(4, 1);
    sys_load();
    xlate_fault(1'b0, LOAD_PAGE_FAULT);
    xlate_fault(1'b1, STORE_PAGE_FAULT);
    $display("all tests passed");
    $finish;
  end

endmodule

/* dcache_bypass.sv */
// ==================================================
// Uncached access unit top. L2_SEL_BIT must lie
// above the page offset.
// ==================================================
`timescale 1ns/1ps

module dcache_bypass
  import bypass_pkg::*;
#(
  parameter int L2_SEL_BIT = 31
) (
  input  logic       clk,
  input  logic       rst,
  // Core
  input  core_req_t  core_req,
  output core_resp_t core_resp,
  // TLB
  output logic       tlb_req_valid,
  output tlb_req_t   tlb_req,
  input  logic       tlb_req_ready,
  input  logic       tlb_resp_valid,
  input  tlb_resp_t  tlb_resp,
  output logic       tlb_resp_ready,
  // L2
  output logic       l2_req_valid,
  output l2_req_t    l2_req,
  input  logic       l2_req_ready,
  input  logic       l2_resp_valid,
  input  l2_resp_t   l2_resp,
  output logic       l2_resp_ready,
  // System bus
  output logic       ar_valid,
  output sys_ar_t    ar,
  input  logic       ar_ready,
  output logic       aw_valid,
  output sys_aw_t    aw,
  input  logic       aw_ready,
  output logic       w_valid,
  output sys_w_t     w,
  input  logic       w_ready,
  input  logic       r_valid,
  input  sys_r_t     r,
  output logic       r_ready,
  input  logic       b_valid,
  input  sys_b_t     b,
  output logic       b_ready
);

  acc_t              acc;
  logic              l2_start;
  logic              sys_start;
  logic              l2_done;
  logic              sys_done;
  logic [DATA_W-1:0] l2_rdata;
  logic [DATA_W-1:0] sys_rdata;

  bypass_ctrl #(
    .L2_SEL_BIT(L2_SEL_BIT)
  ) i_ctrl (
    .clk, .rst, .core_req, .core_resp,
    .tlb_req_valid, .tlb_req, .tlb_req_ready,
    .tlb_resp_valid, .tlb_resp, .tlb_resp_ready,
    .l2_req_ready, .acc, .l2_start, .sys_start,
    .l2_done, .l2_rdata, .sys_done, .sys_rdata
  );

  bypass_l2_port i_l2_port (
    .clk, .rst, .acc, .l2_start,
    .l2_req_valid, .l2_req, .l2_req_ready,
    .l2_resp_valid, .l2_resp, .l2_resp_ready,
    .l2_done, .l2_rdata
  );

  bypass_sysbus_port i_sysbus_port (
    .clk, .rst, .acc, .sys_start,
    .ar_valid, .ar, .ar_ready,
    .aw_valid, .aw, .aw_ready,
    .w_valid, .w, .w_ready,
    .r_valid, .r, .r_ready,
    .b_valid, .b, .b_ready,
    .sys_done, .sys_rdata
  );

endmodule

/* bypass_sysbus_port.sv */
// ==================================================
// Single-beat reads and writes. AW and W complete
// independently; B is expected after both.
// ==================================================
`timescale 1ns/1ps

module bypass_sysbus_port
  import bypass_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  acc_t              acc,
  input  logic              sys_start,
  output logic              ar_valid,
  output sys_ar_t           ar,
  input  logic              ar_ready,
  output logic              aw_valid,
  output sys_aw_t           aw,
  input  logic              aw_ready,
  output logic              w_valid,
  output sys_w_t            w,
  input  logic              w_ready,
  input  logic              r_valid,
  input  sys_r_t            r,
  output logic              r_ready,
  input  logic              b_valid,
  input  sys_b_t            b,
  output logic              b_ready,
  output logic              sys_done,
  output logic [DATA_W-1:0] sys_rdata
);

  logic [PADDR_W-1:0] addr_q;
  logic               ar_valid_q;
  logic               aw_valid_q;
  logic               w_valid_q;
  logic               rd_pend_q;
  logic               wr_pend_q;
  logic               r_hs;
  logic               b_hs;

  // Translation result is gone after sys_start
  always_ff @(posedge clk) begin
    if (sys_start) addr_q <= acc.paddr;
  end

  // ==================================================
  // Request channels
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else if (sys_start) begin
      ar_valid_q <= !acc.we;
      aw_valid_q <= acc.we;
      w_valid_q  <= acc.we;
    end else begin
      if (ar_ready) ar_valid_q <= 1'b0;
      if (aw_ready) aw_valid_q <= 1'b0;
      if (w_ready) w_valid_q <= 1'b0;
    end
  end

  assign ar_valid = ar_valid_q;
  assign aw_valid = aw_valid_q;
  assign w_valid  = w_valid_q;

  assign ar.id   = BUS_ID_W'(acc.tid);
  assign ar.addr = addr_q;
  assign aw.id   = BUS_ID_W'(acc.tid);
  assign aw.addr = addr_q;
  assign w.data  = acc.wdata;
  assign w.strb  = acc.mask;

  // ==================================================
  // Response channels
  // ==================================================
  assign r_hs = r_valid && r_ready;
  assign b_hs = b_valid && b_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else if (sys_start) begin
      rd_pend_q <= !acc.we;
      wr_pend_q <= acc.we;
    end else begin
      if (r_hs) rd_pend_q <= 1'b0;
      if (b_hs) wr_pend_q <= 1'b0;
    end
  end

  assign r_ready   = rd_pend_q;
  assign b_ready   = wr_pend_q;
  assign sys_done  = r_hs || b_hs;
  assign sys_rdata = r.data;

endmodule

/* bypass_l2_port.sv */
// ==================================================
// L2 request is combinational off l2_start and acc.
// Only one read may be outstanding.
// ==================================================
`timescale 1ns/1ps

module bypass_l2_port
  import bypass_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  acc_t              acc,
  input  logic              l2_start,
  output logic              l2_req_valid,
  output l2_req_t           l2_req,
  input  logic              l2_req_ready,
  input  logic              l2_resp_valid,
  input  l2_resp_t          l2_resp,
  output logic              l2_resp_ready,
  output logic              l2_done,
  output logic [DATA_W-1:0] l2_rdata
);

  logic rd_pending_q;
  logic req_hs;
  logic resp_hs;

  // ==================================================
  // Request formatting
  // ==================================================
  assign l2_req_valid = l2_start;

  assign l2_req.paddr    = acc.paddr;
  // Place the 64-bit word and its byte mask in the addressed lane
  assign l2_req.data     = LINE_W'(acc.wdata) << (DATA_W * acc.lane);
  assign l2_req.mask     = (LINE_W / 8)'(acc.mask) << ((DATA_W / 8) * acc.lane);
  assign l2_req.tid      = acc.tid;
  assign l2_req.req_type = acc.we ? REQ_WRITE : REQ_READ;

  assign req_hs  = l2_req_valid && l2_req_ready;
  assign resp_hs = l2_resp_valid && l2_resp_ready;

  // ==================================================
  // Outstanding read
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pending_q <= 1'b0;
    end else if (req_hs && !acc.we) begin
      rd_pending_q <= 1'b1;
    end else if (resp_hs) begin
      rd_pending_q <= 1'b0;
    end
  end

  assign l2_resp_ready = rd_pending_q;

  // Writes need no response from L2
  assign l2_done  = (req_hs && acc.we) || resp_hs;
  assign l2_rdata = l2_resp.data[DATA_W * acc.lane +: DATA_W];

endmodule

/* bypass_ctrl.sv */
// ==================================================
// One access in flight. Core strobes are taken in
// IDLE only; acc.paddr is valid while the TLB answers.
// ==================================================
`timescale 1ns/1ps

module bypass_ctrl
  import bypass_pkg::*;
#(
  parameter int L2_SEL_BIT = 31
) (
  input  logic              clk,
  input  logic              rst,
  input  core_req_t         core_req,
  output core_resp_t        core_resp,
  output logic              tlb_req_valid,
  output tlb_req_t          tlb_req,
  input  logic              tlb_req_ready,
  input  logic              tlb_resp_valid,
  input  tlb_resp_t         tlb_resp,
  output logic              tlb_resp_ready,
  input  logic              l2_req_ready,
  output acc_t              acc,
  output logic              l2_start,
  output logic              sys_start,
  input  logic              l2_done,
  input  logic [DATA_W-1:0] l2_rdata,
  input  logic              sys_done,
  input  logic [DATA_W-1:0] sys_rdata
);

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  logic                we_q;
  logic [VADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]   wdata_q;
  logic [DATA_W/8-1:0] mask_q;
  logic [TID_W-1:0]    tid_q;
  logic                in_resp;
  logic                is_l2;
  logic                xlate_excp;
  logic                tlb_resp_hs;

  // ==================================================
  // Request capture
  // ==================================================
  always_ff @(posedge clk) begin
    if (state_q == IDLE && (core_req.re || core_req.we)) begin
      we_q    <= core_req.we;
      addr_q  <= core_req.addr;
      wdata_q <= core_req.wdata;
      mask_q  <= core_req.mask;
    end
  end

  assign tlb_req_valid   = (state_q == XLATE_REQ);
  assign tlb_req.vpn     = addr_q[VADDR_W-1:PAGE_OFS_W];
  assign tlb_req.access_type = we_q ? STORE : LOAD;

  // ==================================================
  // Translation result and routing
  // ==================================================
  assign acc.we    = we_q;
  assign acc.paddr = {tlb_resp.ppn, addr_q[PAGE_OFS_W-1:0]};
  assign acc.lane  = addr_q[4:3];
  assign acc.wdata = wdata_q;
  assign acc.mask  = mask_q;
  assign acc.tid   = tid_q;

  assign in_resp    = (state_q == XLATE_RESP);
  assign is_l2      = acc.paddr[L2_SEL_BIT];
  assign xlate_excp = in_resp && tlb_resp_valid && tlb_resp.excp_valid;

  // L2 back-pressure stalls the TLB response
  assign tlb_resp_ready = in_resp && (tlb_resp.excp_valid || !is_l2 || l2_req_ready);
  assign tlb_resp_hs    = tlb_resp_valid && tlb_resp_ready;

  assign l2_start  = in_resp && tlb_resp_valid && !tlb_resp.excp_valid && is_l2;
  assign sys_start = in_resp && tlb_resp_valid && !tlb_resp.excp_valid && !is_l2;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (core_req.re || core_req.we) state_d = XLATE_REQ;
      end
      XLATE_REQ: begin
        if (tlb_req_ready) state_d = XLATE_RESP;
      end
      XLATE_RESP: begin
        if (tlb_resp_hs) begin
          // L2 writes finish on the request handshake
          if (tlb_resp.excp_valid || (is_l2 && we_q)) state_d = IDLE;
          else state_d = ACCESS;
        end
      end
      ACCESS: begin
        if (l2_done || sys_done) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      tid_q   <= '0;
    end else begin
      state_q <= state_d;
      if (core_resp.valid) tid_q <= tid_q + 1'b1;
    end
  end

  // ==================================================
  // Response merge
  // ==================================================
  assign core_resp.valid      = xlate_excp || l2_done || sys_done;
  assign core_resp.excp_valid = xlate_excp;
  assign core_resp.excp_cause = xlate_excp ? tlb_resp.excp_cause : NONE;
  assign core_resp.rdata      = sys_done ? sys_rdata : l2_rdata;

endmodule

/* bypass_pkg.sv */
// ==================================================
// Shared widths, enums and port structs for the
// uncached data access unit. Sv39 layout assumed.
// ==================================================
package bypass_pkg;

  localparam int VADDR_W    = 39;
  localparam int PADDR_W    = 40;
  localparam int PAGE_OFS_W = 12;
  localparam int PPN_W      = 28;
  localparam int VPN_W      = 27;
  localparam int DATA_W     = 64;
  localparam int LINE_W     = 256;
  localparam int LANE_IDX_W = 2;
  localparam int TID_W      = 4;
  localparam int BUS_ID_W   = 8;

  typedef enum logic {LOAD, STORE} access_type_e;

  typedef enum logic {REQ_READ, REQ_WRITE} l2_req_type_e;

  // RISC-V exception codes
  typedef enum logic [3:0] {
    NONE             = 4'd0,
    LOAD_PAGE_FAULT  = 4'd13,
    STORE_PAGE_FAULT = 4'd15
  } excp_cause_e;

  typedef enum logic [1:0] {IDLE, XLATE_REQ, XLATE_RESP, ACCESS} ctrl_state_e;

  // ==================================================
  // Core and TLB
  // ==================================================
  typedef struct packed {
    logic                re;
    logic                we;
    logic [VADDR_W-1:0]  addr;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] mask;
  } core_req_t;

  typedef struct packed {
    logic              valid;
    logic              excp_valid;
    excp_cause_e       excp_cause;
    logic [DATA_W-1:0] rdata;
  } core_resp_t;

  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    access_type_e     access_type;
  } tlb_req_t;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic             excp_valid;
    excp_cause_e      excp_cause;
  } tlb_resp_t;

  // ==================================================
  // L2 and system bus
  // ==================================================
  typedef struct packed {
    logic [PADDR_W-1:0]  paddr;
    logic [LINE_W-1:0]   data;
    logic [LINE_W/8-1:0] mask;
    logic [TID_W-1:0]    tid;
    l2_req_type_e        req_type;
  } l2_req_t;

  typedef struct packed {
    logic [LINE_W-1:0] data;
    logic [TID_W-1:0]  tid;
  } l2_resp_t;

  typedef struct packed {
    logic [BUS_ID_W-1:0] id;
    logic [PADDR_W-1:0]  addr;
  } sys_ar_t;

  typedef struct packed {
    logic [BUS_ID_W-1:0] id;
    logic [PADDR_W-1:0]  addr;
  } sys_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
  } sys_w_t;

  typedef struct packed {
    logic [BUS_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
  } sys_r_t;

  typedef struct packed {
    logic [BUS_ID_W-1:0] id;
  } sys_b_t;

  // Captured access, ctrl to ports
  typedef struct packed {
    logic                  we;
    logic [PADDR_W-1:0]    paddr;
    logic [LANE_IDX_W-1:0] lane;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W/8-1:0]   mask;
    logic [TID_W-1:0]      tid;
  } acc_t;

endpackage
